/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run tb_dcache, result in $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary -Wno-fatal -f project.f --top-module tb_dcache -o tb_dcache
	./obj_dir/tb_dcache | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* dcache_bus_master.sv */
`timescale 1ns/10ps
`include "dcache_macros.svh"

module dcache_bus_master (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_start,
    input  logic                 i_start_we,
    input  logic                 i_start_line,
    input  dcache_pkg::wb_addr_t i_start_adr,
    input  dcache_pkg::data_t    i_wdata,
    input  dcache_pkg::data_t    i_wb_dat,
    input  logic                 i_wb_ack,
    input  logic                 i_wb_err,
    output logic                 o_wb_cyc,
    output logic                 o_wb_stb,
    output logic                 o_wb_we,
    output dcache_pkg::wb_addr_t o_wb_adr,
    output logic                 o_wb_burst4,
    output logic                 o_beat,
    output logic                 o_done,
    output dcache_pkg::off_t     o_cnt,
    output dcache_pkg::line_t    o_line,
    output logic                 o_xfer_err
);
    import dcache_pkg::*;

    logic                       line_mode;
    logic                       err_seen;
    logic [`WB_ADDR_W-1:`OFF_W] base_adr;
    off_t                       cnt;
    line_t                      line_q;
    data_t                      beat_word;

    assign o_beat      = o_wb_cyc & o_wb_stb & (i_wb_ack | i_wb_err);
    assign o_done      = o_beat & (~line_mode | (&cnt)); // Single beat, or the fourth one
    assign o_cnt       = cnt;
    assign o_wb_adr    = {base_adr, cnt};
    assign o_wb_burst4 = o_wb_cyc & line_mode;
    assign o_xfer_err  = err_seen | (o_beat & i_wb_err);
    assign beat_word   = o_wb_we ? i_wdata : i_wb_dat;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_cyc  <= 1'b0;
            o_wb_stb  <= 1'b0;
            o_wb_we   <= 1'b0;
            line_mode <= 1'b0;
            err_seen  <= 1'b0;
            cnt       <= '0;
        end else if (i_start) begin
            // A new start may follow the last writeback beat directly
            o_wb_cyc  <= 1'b1;
            o_wb_stb  <= 1'b1;
            o_wb_we   <= i_start_we;
            line_mode <= i_start_line;
            err_seen  <= 1'b0;
            cnt       <= i_start_line ? '0 : i_start_adr[`OFF_W-1:0];
        end else if (o_done) begin
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            err_seen <= o_xfer_err;
        end else if (o_beat) begin
            cnt      <= cnt + 1'b1;
            err_seen <= o_xfer_err;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            base_adr <= i_start_adr[`WB_ADDR_W-1:`OFF_W];
        end
        if (o_beat) begin
            line_q[cnt*`DATA_W +: `DATA_W] <= beat_word;
        end
    end

    // The word of the current beat goes straight into its slot
    always_comb begin
        o_line = line_q;
        o_line[cnt*`DATA_W +: `DATA_W] = beat_word;
    end

endmodule

/* dcache_cases.txt */
// op(0 rd 1 wr) addr data sel cache_en exp_data exp_exc exp_cycles (ff means any count)
// Read miss then hits on the same line, with byte writes merged in
0 001004 0000 3 1 4a5e 0 01
0 001005 0000 3 1 4a5f 0 00
1 001005 1234 1 1 0000 0 00
0 001005 0000 3 1 4a34 0 00
1 001005 abcd 2 1 0000 0 00
0 001005 0000 3 1 ab34 0 00
1 001006 beef 3 1 0000 0 00
0 001006 0000 3 1 beef 0 00
// Three tags on set 1 force writebacks
1 002004 2222 3 1 0000 0 01
1 003004 3333 3 1 0000 0 ff
0 001005 0000 3 0 ab34 0 01
0 001006 0000 3 0 beef 0 01
0 001007 0000 3 0 4a5d 0 01
0 002004 0000 3 1 2222 0 00
0 003004 0000 3 1 3333 0 00
0 001005 0000 3 1 ab34 0 ff
0 002004 0000 3 0 2222 0 01
// Uncached pass-through with byte lanes
1 004000 1357 1 0 0000 0 01
0 004000 0000 3 0 1a57 0 01
1 004001 c3c3 2 0 0000 0 01
0 004001 0000 3 0 c35b 0 01
// Illegal addresses, then the error region
0 000700 0000 3 1 0000 1 00
1 000010 5555 3 0 0000 1 00
0 ff0010 0000 3 0 0000 1 01
1 ff0020 1111 3 0 0000 1 01
0 001006 0000 3 1 beef 0 00
2 000000 0000 0 0 0000 0 00

/* dcache_ctrl.sv */
`timescale 1ns/10ps
`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_req,
    input  logic                 i_we,
    input  dcache_pkg::wb_addr_t i_addr,
    input  dcache_pkg::data_t    i_wdata,
    input  logic [1:0]           i_sel,
    input  logic                 i_cache_en,
    output dcache_pkg::data_t    o_rdata,
    output logic                 o_ack,
    output logic                 o_exception,
    output dcache_pkg::idx_t     o_idx,
    output dcache_pkg::entry_t   o_entry,
    output logic                 o_we0,
    output logic                 o_we1,
    input  dcache_pkg::entry_t   i_way0,
    input  dcache_pkg::entry_t   i_way1,
    output logic                 o_start,
    output logic                 o_start_we,
    output logic                 o_start_line,
    output dcache_pkg::wb_addr_t o_start_adr,
    input  logic                 i_beat,
    input  logic                 i_done,
    input  dcache_pkg::off_t     i_cnt,
    input  dcache_pkg::line_t    i_line,
    input  logic                 i_xfer_err,
    input  dcache_pkg::data_t    i_wb_dat,
    output dcache_pkg::data_t    o_wb_dat,
    output logic [1:0]           o_wb_sel
);
    import dcache_pkg::*;

    dc_state_e state, state_nxt;
    tag_t      tag;
    idx_t      idx;
    off_t      off;
    logic      illegal;
    logic      hit0, hit1, hit;
    logic      evict_need;
    logic      victim, cur_way;
    logic      way_q, last_vict;
    logic      ram_wr;
    entry_t    sel_entry, hit_entry;
    line_t     way_line, rd_line, merged_line;
    data_t     old_word, new_word;

    assign tag     = i_addr[`WB_ADDR_W-1:`WB_ADDR_W-`TAG_W];
    assign idx     = i_addr[`OFF_W+`IDX_W-1:`OFF_W];
    assign off     = i_addr[`OFF_W-1:0];
    assign illegal = i_addr < `FIRST_PAGE;

    assign hit0 = i_way0[`VALID_BIT] && (i_way0[`TAG_LSB +: `TAG_W] == tag);
    assign hit1 = i_way1[`VALID_BIT] && (i_way1[`TAG_LSB +: `TAG_W] == tag);
    assign hit  = hit0 | hit1;

    // Only when both ways hold dirty lines does the victim need a writeback
    assign evict_need = (&i_way0[`DIRTY_BIT:`VALID_BIT]) & (&i_way1[`DIRTY_BIT:`VALID_BIT]);

    always_comb begin
        if (!i_way0[`VALID_BIT]) victim = 1'b0;
        else if (!i_way1[`VALID_BIT]) victim = 1'b1;
        else if (!i_way0[`DIRTY_BIT]) victim = 1'b0;
        else if (!i_way1[`DIRTY_BIT]) victim = 1'b1;
        else victim = ~last_vict;
    end

    assign cur_way   = (state == LOOKUP) ? victim : way_q;
    assign sel_entry = cur_way ? i_way1 : i_way0;
    assign hit_entry = hit1 ? i_way1 : i_way0;
    assign way_line  = sel_entry[`LINE_LSB +: `LINE_W];

    // Byte merge for the write into the selected way
    assign old_word = way_line[off*`DATA_W +: `DATA_W];
    assign new_word = {i_sel[1] ? i_wdata[15:8] : old_word[15:8],
                       i_sel[0] ? i_wdata[7:0] : old_word[7:0]};

    always_comb begin
        merged_line = way_line;
        merged_line[off*`DATA_W +: `DATA_W] = new_word;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (i_req && !illegal) state_nxt = i_cache_en ? LOOKUP : UNCACHED;
            end
            LOOKUP: begin
                if (hit) state_nxt = i_we ? WRITE : IDLE;
                else state_nxt = evict_need ? EVICT : FILL;
            end
            EVICT: begin
                if (i_done) state_nxt = FILL;
            end
            FILL: begin
                if (i_done) state_nxt = (i_we && !i_xfer_err) ? WRITE_WAIT : IDLE;
            end
            WRITE_WAIT: state_nxt = WRITE;
            WRITE:      state_nxt = IDLE;
            UNCACHED: begin
                if (i_beat) state_nxt = IDLE; // Pass-through is always a single beat
            end
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state     <= IDLE;
            way_q     <= 1'b0;
            last_vict <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == LOOKUP && hit) begin
                way_q <= hit1;
            end else if (state == LOOKUP) begin
                way_q     <= victim;
                last_vict <= victim;
            end
        end
    end

    always_comb begin
        o_start      = 1'b0;
        o_start_we   = 1'b0;
        o_start_line = 1'b1;
        o_start_adr  = {tag, idx, {`OFF_W{1'b0}}};
        case (state)
            IDLE: begin
                if (i_req && !illegal && !i_cache_en) begin
                    o_start      = 1'b1;
                    o_start_we   = i_we;
                    o_start_line = 1'b0;
                    o_start_adr  = i_addr;
                end
            end
            LOOKUP: begin
                if (!hit) begin
                    o_start    = 1'b1;
                    o_start_we = evict_need;
                    if (evict_need) begin
                        o_start_adr = {sel_entry[`TAG_LSB +: `TAG_W], idx, {`OFF_W{1'b0}}};
                    end
                end
            end
            EVICT:   o_start = i_done; // Refill follows the writeback with cyc held
            default: o_start = 1'b0;
        endcase
    end

    assign o_idx   = idx;
    assign ram_wr  = (state == WRITE) | (state == FILL && i_done && !i_xfer_err);
    assign o_we0   = ram_wr & ~way_q;
    assign o_we1   = ram_wr & way_q;
    assign o_entry = (state == WRITE) ? {tag, merged_line, 1'b1, 1'b1}
                                      : {tag, i_line, 1'b0, 1'b1};

    assign rd_line = (state == FILL) ? i_line : hit_entry[`LINE_LSB +: `LINE_W];
    assign o_rdata = (state == UNCACHED) ? i_wb_dat : rd_line[off*`DATA_W +: `DATA_W];

    assign o_ack = (state == LOOKUP && hit && !i_we)
                 | (state == FILL && i_done && (!i_we || i_xfer_err))
                 | (state == WRITE)
                 | (state == UNCACHED && i_beat);
    assign o_exception = (state == IDLE && i_req && illegal)
                       | (state == UNCACHED && i_beat && i_xfer_err);

    assign o_wb_dat = (state == EVICT) ? way_line[i_cnt*`DATA_W +: `DATA_W] : i_wdata;
    assign o_wb_sel = (state == UNCACHED) ? i_sel : 2'b11;

endmodule

/* dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Addresses count words of 16 bits
`define WB_ADDR_W 24
`define DATA_W 16

// Address split is tag [23:8], index [7:2], word offset [1:0]
`define TAG_W 16
`define IDX_W 6
`define OFF_W 2
`define LINE_W 64

// Entry layout from the top is tag, line, dirty and valid
`define ENTRY_W 82
`define VALID_BIT 0
`define DIRTY_BIT 1
`define LINE_LSB 2
`define TAG_LSB 66

// Anything below this word address is illegal
`define FIRST_PAGE 24'h000800

`endif

/* dcache_pkg.sv */
`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [`DATA_W-1:0]    data_t;
    typedef logic [`TAG_W-1:0]     tag_t;
    typedef logic [`IDX_W-1:0]     idx_t;
    typedef logic [`OFF_W-1:0]     off_t;
    typedef logic [`LINE_W-1:0]    line_t;
    typedef logic [`ENTRY_W-1:0]   entry_t;

    // WRITE_WAIT lets the refilled entry reach the RAM output
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        EVICT,
        FILL,
        WRITE_WAIT,
        WRITE,
        UNCACHED
    } dc_state_e;

endpackage

/* dcache_top.sv */
`timescale 1ns/10ps

module dcache_top (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_req,
    input  logic                 i_we,
    input  dcache_pkg::wb_addr_t i_addr,
    input  dcache_pkg::data_t    i_wdata,
    input  logic [1:0]           i_sel,
    input  logic                 i_cache_en,
    output dcache_pkg::data_t    o_rdata,
    output logic                 o_ack,
    output logic                 o_exception,
    output logic                 o_wb_cyc,
    output logic                 o_wb_stb,
    output logic                 o_wb_we,
    output dcache_pkg::wb_addr_t o_wb_adr,
    output dcache_pkg::data_t    o_wb_dat,
    output logic [1:0]           o_wb_sel,
    output logic                 o_wb_burst4,
    input  dcache_pkg::data_t    i_wb_dat,
    input  logic                 i_wb_ack,
    input  logic                 i_wb_err
);
    import dcache_pkg::*;

    idx_t     ram_idx;
    entry_t   ram_wentry, way0_q, way1_q;
    logic     we0, we1;
    logic     start, start_we, start_line;
    wb_addr_t start_adr;
    logic     beat, done, xfer_err;
    off_t     cnt;
    line_t    xfer_line;

    dcache_ctrl u_ctrl (
        .i_clk, .i_rst, .i_req, .i_we, .i_addr, .i_wdata, .i_sel, .i_cache_en,
        .o_rdata, .o_ack, .o_exception,
        .o_idx(ram_idx), .o_entry(ram_wentry), .o_we0(we0), .o_we1(we1),
        .i_way0(way0_q), .i_way1(way1_q),
        .o_start(start), .o_start_we(start_we), .o_start_line(start_line),
        .o_start_adr(start_adr), .i_beat(beat), .i_done(done), .i_cnt(cnt),
        .i_line(xfer_line), .i_xfer_err(xfer_err),
        .i_wb_dat, .o_wb_dat, .o_wb_sel
    );

    dcache_way_ram u_way0 (
        .i_clk, .i_rst, .i_we(we0), .i_idx(ram_idx), .i_wdata(ram_wentry), .o_rdata(way0_q)
    );

    dcache_way_ram u_way1 (
        .i_clk, .i_rst, .i_we(we1), .i_idx(ram_idx), .i_wdata(ram_wentry), .o_rdata(way1_q)
    );

    // Outgoing words come from the controller, which also drives o_wb_dat
    dcache_bus_master u_bus (
        .i_clk, .i_rst,
        .i_start(start), .i_start_we(start_we), .i_start_line(start_line),
        .i_start_adr(start_adr), .i_wdata(o_wb_dat),
        .i_wb_dat, .i_wb_ack, .i_wb_err,
        .o_wb_cyc, .o_wb_stb, .o_wb_we, .o_wb_adr, .o_wb_burst4,
        .o_beat(beat), .o_done(done), .o_cnt(cnt), .o_line(xfer_line),
        .o_xfer_err(xfer_err)
    );

endmodule

/* dcache_way_ram.sv */
`timescale 1ns/10ps
`include "dcache_macros.svh"

module dcache_way_ram (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_we,
    input  dcache_pkg::idx_t   i_idx,
    input  dcache_pkg::entry_t i_wdata,
    output dcache_pkg::entry_t o_rdata
);
    import dcache_pkg::*;

    entry_t mem [1 << `IDX_W];
    idx_t   sweep_idx;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            sweep_idx <= sweep_idx + 1'b1; // Visits every set while reset is held
        end else begin
            sweep_idx <= '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            mem[sweep_idx] <= '0; // Invalidate one set per cycle
        end else if (i_we) begin
            mem[i_idx] <= i_wdata;
        end
        o_rdata <= mem[i_idx]; // Old contents on a same-cycle write
    end

endmodule

/* project.f */
+incdir+.
dcache_pkg.sv
dcache_way_ram.sv
dcache_bus_master.sv
dcache_ctrl.sv
dcache_top.sv
tb_wb_mem.sv
tb_dcache_checker.sv
tb_dcache.sv

/* tb_dcache.sv */
`timescale 1ns/10ps
`include "dcache_macros.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int MAX_CASES = 64;
    localparam int RST_CYCLES = 8 + (1 << `IDX_W); // Covers the valid-bit sweep

    logic        i_clk, i_rst, i_req, i_we, i_cache_en;
    wb_addr_t    i_addr, o_wb_adr;
    data_t       i_wdata, o_rdata, o_wb_dat, wb_rdat;
    logic [1:0]  i_sel, o_wb_sel;
    logic        o_ack, o_exception;
    logic        o_wb_cyc, o_wb_stb, o_wb_we, o_wb_burst4, wb_ack, wb_err;
    logic [31:0] case_mem [0:8*MAX_CASES-1];
    int          num_cases, case_num, pass_cnt, fail_cnt;
    logic        is_read, exp_exc, loaded;
    data_t       exp_data;
    logic [7:0]  exp_cyc;

    dcache_top i_dcache_top (
        .i_clk, .i_rst, .i_req, .i_we, .i_addr, .i_wdata, .i_sel, .i_cache_en,
        .o_rdata, .o_ack, .o_exception,
        .o_wb_cyc, .o_wb_stb, .o_wb_we, .o_wb_adr, .o_wb_dat, .o_wb_sel, .o_wb_burst4,
        .i_wb_dat(wb_rdat), .i_wb_ack(wb_ack), .i_wb_err(wb_err)
    );

    tb_wb_mem u_mem (
        .i_clk, .i_rst, .i_cyc(o_wb_cyc), .i_stb(o_wb_stb), .i_we(o_wb_we),
        .i_adr(o_wb_adr), .i_dat(o_wb_dat), .i_sel(o_wb_sel),
        .o_dat(wb_rdat), .o_ack(wb_ack), .o_err(wb_err)
    );

    tb_dcache_checker u_check (
        .i_clk, .i_req, .i_cache_en, .i_ack(o_ack), .i_exception(o_exception),
        .i_rdata(o_rdata), .i_wb_cyc(o_wb_cyc), .i_wb_burst4(o_wb_burst4),
        .i_case_num(case_num), .i_is_read(is_read),
        .i_exp_data(exp_data), .i_exp_exc(exp_exc), .i_exp_cyc(exp_cyc),
        .o_pass_cnt(pass_cnt), .o_fail_cnt(fail_cnt)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    initial begin
        wait (loaded);
        #((num_cases * 200 + RST_CYCLES) * 8);
        $display("Run timed out before all cases finished");
        $display("Verification failed");
        $finish;
    end

    initial begin
        i_rst = 1'b1;
        i_req = 1'b0;
        i_we = 1'b0;
        i_addr = '0;
        i_wdata = '0;
        i_sel = 2'b00;
        i_cache_en = 1'b0;
        case_num = 0;
        is_read = 1'b0;
        exp_data = '0;
        exp_exc = 1'b0;
        exp_cyc = 8'h00;
        loaded = 1'b0;
        for (int i = 0; i < 8 * MAX_CASES; i++) case_mem[i] = 32'd2; // Op 2 ends the list
        $readmemh("dcache_cases.txt", case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_mem[8*num_cases] < 32'd2) num_cases++;
        loaded = 1'b1;
        repeat (RST_CYCLES) @(posedge i_clk);
        #1 i_rst = 1'b0;
        for (int n = 0; n < num_cases; n++) begin
            @(posedge i_clk);
            #1;
            case_num = n;
            i_we = case_mem[8*n][0];
            is_read = !case_mem[8*n][0];
            i_addr = case_mem[8*n+1][`WB_ADDR_W-1:0];
            i_wdata = case_mem[8*n+2][`DATA_W-1:0];
            i_sel = case_mem[8*n+3][1:0];
            i_cache_en = case_mem[8*n+4][0];
            exp_data = case_mem[8*n+5][`DATA_W-1:0];
            exp_exc = case_mem[8*n+6][0];
            exp_cyc = case_mem[8*n+7][7:0];
            i_req = 1'b1;
            do @(negedge i_clk); while (!(o_ack || o_exception));
            @(posedge i_clk);
            #1 i_req = 1'b0;
        end
        repeat (2) @(posedge i_clk);
        $display("Cases %0d, passed %0d, failed %0d", num_cases, pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt == num_cases) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* tb_dcache_checker.sv */
`timescale 1ns/10ps
`include "dcache_macros.svh"

module tb_dcache_checker (
    input  logic               i_clk,
    input  logic               i_req,
    input  logic               i_cache_en,
    input  logic               i_ack,
    input  logic               i_exception,
    input  logic [`DATA_W-1:0] i_rdata,
    input  logic               i_wb_cyc,
    input  logic               i_wb_burst4,
    input  int                 i_case_num,
    input  logic               i_is_read,
    input  logic [`DATA_W-1:0] i_exp_data,
    input  logic               i_exp_exc,
    input  logic [7:0]         i_exp_cyc,
    output int                 o_pass_cnt,
    output int                 o_fail_cnt
);
    int   cyc_cnt = 0;
    logic cyc_prev = 1'b0;
    logic burst_bad = 1'b0;

    initial begin
        o_pass_cnt = 0;
        o_fail_cnt = 0;
    end

    function automatic void report_fail(input string msg);
        $display("[FAIL] t=%0t case %0d %s", $time, i_case_num, msg);
        o_fail_cnt++;
    endfunction

    // Outputs are settled at the falling edge
    always @(negedge i_clk) begin
        if (i_wb_cyc && !cyc_prev) cyc_cnt++;
        cyc_prev = i_wb_cyc;
        // Only cached accesses move whole lines
        if (i_wb_cyc && (i_wb_burst4 !== i_cache_en)) burst_bad = 1'b1;
        if (i_req && (i_ack || i_exception)) begin
            if (i_exception !== i_exp_exc)
                report_fail($sformatf("exception %0b, expected %0b", i_exception, i_exp_exc));
            else if (i_exp_exc && (i_ack !== (i_exp_cyc != 8'h00)))
                report_fail($sformatf("ack %0b with the exception is wrong", i_ack));
            else if (i_is_read && !i_exp_exc && i_rdata !== i_exp_data)
                report_fail($sformatf("read %h, expected %h", i_rdata, i_exp_data));
            else if (i_exp_cyc != 8'hff && cyc_cnt != int'(i_exp_cyc))
                report_fail($sformatf("%0d bus cycles, expected %0d", cyc_cnt, i_exp_cyc));
            else if (burst_bad)
                report_fail("o_wb_burst4 does not match the transfer type");
            else begin
                $display("[PASS] t=%0t case %0d", $time, i_case_num);
                o_pass_cnt++;
            end
            cyc_cnt = 0;
            burst_bad = 1'b0;
        end
    end

endmodule

/* tb_wb_mem.sv */
`timescale 1ns/10ps
`include "dcache_macros.svh"

module tb_wb_mem (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_cyc,
    input  logic                  i_stb,
    input  logic                  i_we,
    input  logic [`WB_ADDR_W-1:0] i_adr,
    input  logic [`DATA_W-1:0]    i_dat,
    input  logic [1:0]            i_sel,
    output logic [`DATA_W-1:0]    o_dat,
    output logic                  o_ack,
    output logic                  o_err
);
    logic [`DATA_W-1:0] mem [logic [`WB_ADDR_W-1:0]];
    logic [`DATA_W-1:0] word;

    // Untouched words hold a pattern of their own address
    function automatic logic [`DATA_W-1:0] read_word(input logic [`WB_ADDR_W-1:0] a);
        if (mem.exists(a)) return mem[a];
        return a[15:0] ^ {8'h00, a[23:16]} ^ 16'h5a5a;
    endfunction

    always @(posedge i_clk) begin
        if (i_rst) begin
            o_ack <= 1'b0;
            o_err <= 1'b0;
            o_dat <= '0;
        end else begin
            o_ack <= 1'b0;
            o_err <= 1'b0;
            if (i_cyc && i_stb && !o_ack && !o_err) begin
                if (i_adr >= 24'hff0000) begin
                    o_err <= 1'b1; // Error region never acks
                end else begin
                    word = read_word(i_adr);
                    if (i_we) begin
                        if (i_sel[1]) word[15:8] = i_dat[15:8];
                        if (i_sel[0]) word[7:0] = i_dat[7:0];
                        mem[i_adr] = word;
                    end
                    o_dat <= word;
                    o_ack <= 1'b1;
                end
            end
        end
    end

endmodule
